/* hdl/tlu_bus_pkg.sv */
package tlu_bus_pkg;

    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;

    // write strobes a soft reset, read gives lost words
    localparam bus_addr_t addr_ctrl = 16'd0;
    localparam bus_addr_t addr_cfg1 = 16'd1;
    localparam bus_addr_t addr_cfg2 = 16'd2;
    localparam bus_addr_t addr_timeout = 16'd3;
    // trigger number readback, four bytes LSB first
    localparam bus_addr_t addr_tlu_num0 = 16'd4;

    // decoded view of registers 1 to 3
    typedef struct packed {
        // tlu_mode_e encoding
        logic [1:0] mode;
        logic       msb_first;
        logic       disable_veto;
        // zero selects 32 clock cycles
        logic [4:0] trigger_clock_cycles;
        logic       enable_reset;
        logic       invert_lemo;
        logic       write_timestamp;
        // zero means wait forever
        logic [7:0] low_timeout;
    } tlu_cfg_t;

endpackage

/* hdl/tlu_trig_pkg.sv */
package tlu_trig_pkg;

    typedef enum logic [1:0] {
        mode_disabled         = 2'd0,
        mode_no_handshake     = 2'd1,
        mode_simple_handshake = 2'd2,
        mode_data_handshake   = 2'd3
    } tlu_mode_e;

    typedef logic [31:0] timestamp_t;
    typedef logic [31:0] trig_num_t;

    // payload holds trigger number or timestamp
    typedef struct packed {
        logic        marker;
        logic [30:0] payload;
    } tlu_word_t;

    typedef struct packed {
        logic trigger;
        logic trigger_flag;
        logic reset_level;
        logic reset_flag;
    } tlu_inputs_t;

    // BUS_CLK cycles per TLU_CLOCK half period
    localparam int tlu_clock_half_period = 4;
    localparam int fifo_depth = 8;

endpackage

/* hdl/tlu_regs.sv */
`timescale 1ns/100ps

module tlu_regs (
    input  logic                    BUS_CLK,
    input  logic                    RST,
    input  tlu_bus_pkg::bus_addr_t  BUS_ADD,
    input  tlu_bus_pkg::bus_data_t  BUS_DATA_IN,
    input  logic                    BUS_WR,
    output tlu_bus_pkg::bus_data_t  BUS_DATA_OUT,
    input  tlu_bus_pkg::bus_data_t  lost_count,
    input  tlu_trig_pkg::trig_num_t last_trigger_number,
    output tlu_bus_pkg::tlu_cfg_t   cfg,
    output logic                    soft_rst
);
    import tlu_bus_pkg::*;

    bus_data_t   reg_cfg1;
    bus_data_t   reg_cfg2;
    bus_data_t   reg_timeout;
    logic [31:8] trig_num_buf;
    logic        clr;

    assign clr = RST || soft_rst;

    // any write to address 0 resets the controller one cycle later
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            soft_rst <= 1'b0;
        else
            soft_rst <= BUS_WR && (BUS_ADD == addr_ctrl);
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (clr)
        begin
            reg_cfg1 <= '0;
            reg_cfg2 <= '0;
            reg_timeout <= '0;
        end
        else if (BUS_WR)
        begin
            case (BUS_ADD)
                addr_cfg1:    reg_cfg1 <= BUS_DATA_IN;
                addr_cfg2:    reg_cfg2 <= BUS_DATA_IN;
                addr_timeout: reg_timeout <= BUS_DATA_IN;
                default:      ;
            endcase
        end
    end

    // snapshot while the low byte is addressed keeps all four bytes coherent
    always_ff @(posedge BUS_CLK)
    begin
        if (clr)
            trig_num_buf <= '0;
        else if (BUS_ADD == addr_tlu_num0)
            trig_num_buf <= last_trigger_number[31:8];
    end

    always_ff @(posedge BUS_CLK)
    begin
        case (BUS_ADD)
            addr_ctrl:
                BUS_DATA_OUT <= lost_count;
            addr_cfg1:
                BUS_DATA_OUT <= reg_cfg1;
            addr_cfg2:
                BUS_DATA_OUT <= reg_cfg2;
            addr_timeout:
                BUS_DATA_OUT <= reg_timeout;
            // low byte taken from the same value the buffer loads
            addr_tlu_num0:
                BUS_DATA_OUT <= last_trigger_number[7:0];
            addr_tlu_num0 + 16'd1:
                BUS_DATA_OUT <= trig_num_buf[15:8];
            addr_tlu_num0 + 16'd2:
                BUS_DATA_OUT <= trig_num_buf[23:16];
            addr_tlu_num0 + 16'd3:
                BUS_DATA_OUT <= trig_num_buf[31:24];
            default:
                BUS_DATA_OUT <= '0;
        endcase
    end

    // register 1 with bits 7:4 spare
    assign cfg.mode = reg_cfg1[1:0];
    assign cfg.msb_first = reg_cfg1[2];
    assign cfg.disable_veto = reg_cfg1[3];

    // register 2
    assign cfg.trigger_clock_cycles = reg_cfg2[4:0];
    assign cfg.enable_reset = reg_cfg2[5];
    assign cfg.invert_lemo = reg_cfg2[6];
    assign cfg.write_timestamp = reg_cfg2[7];

    // register 3
    assign cfg.low_timeout = reg_timeout;

endmodule

/* hdl/tlu_input_select.sv */
`timescale 1ns/100ps

module tlu_input_select (
    input  logic                      BUS_CLK,
    input  logic                      RST,
    input  logic                      soft_rst,
    input  tlu_bus_pkg::tlu_cfg_t     cfg,
    input  logic                      RJ45_TRIGGER,
    input  logic                      LEMO_TRIGGER,
    input  logic                      RJ45_RESET,
    input  logic                      LEMO_RESET,
    output tlu_trig_pkg::tlu_inputs_t inputs,
    output logic                      RJ45_ENABLED
);
    import tlu_trig_pkg::*;

    // bit order rj45 trigger, rj45 reset, lemo trigger, lemo reset
    logic [3:0] sync1;
    logic [3:0] sync2;
    logic       lemo_trigger;
    logic       trigger;
    logic       reset_level;
    logic       trigger_prev;
    logic       reset_prev;
    logic       trigger_flag;
    logic       reset_flag;
    logic       clr;

    assign clr = RST || soft_rst;
    assign lemo_trigger = cfg.invert_lemo ? !LEMO_TRIGGER : LEMO_TRIGGER;

    always_ff @(posedge BUS_CLK)
    begin
        sync1 <= {RJ45_TRIGGER, RJ45_RESET, lemo_trigger, LEMO_RESET};
        sync2 <= sync1;
    end

    // an unplugged RJ45 connector reads both lines high
    always_ff @(posedge BUS_CLK)
    begin
        if (clr)
            RJ45_ENABLED <= 1'b0;
        else if ((sync2[3] && sync2[2] && !RJ45_ENABLED) || cfg.mode == mode_disabled)
            RJ45_ENABLED <= 1'b0;
        else
            RJ45_ENABLED <= 1'b1;
    end

    assign trigger = RJ45_ENABLED ? sync2[3] : sync2[1];
    assign reset_level = RJ45_ENABLED ? sync2[2] : sync2[0];

    // rising edges, registered
    always_ff @(posedge BUS_CLK)
    begin
        if (clr)
        begin
            trigger_prev <= 1'b0;
            reset_prev <= 1'b0;
            trigger_flag <= 1'b0;
            reset_flag <= 1'b0;
        end
        else
        begin
            trigger_prev <= trigger;
            reset_prev <= reset_level;
            trigger_flag <= trigger && !trigger_prev;
            reset_flag <= reset_level && !reset_prev && cfg.enable_reset;
        end
    end

    assign inputs.trigger = trigger;
    assign inputs.trigger_flag = trigger_flag;
    assign inputs.reset_level = reset_level;
    assign inputs.reset_flag = reset_flag;

endmodule

/* hdl/tlu_handshake_fsm.sv */
`timescale 1ns/100ps

module tlu_handshake_fsm (
    input  logic                      BUS_CLK,
    input  logic                      RST,
    input  logic                      soft_rst,
    input  tlu_bus_pkg::tlu_cfg_t     cfg,
    input  tlu_trig_pkg::tlu_inputs_t inputs,
    input  logic                      EXT_VETO,
    output logic                      fifo_write,
    output tlu_trig_pkg::tlu_word_t   fifo_word,
    output tlu_trig_pkg::trig_num_t   last_trigger_number,
    output logic                      TLU_BUSY,
    output logic                      TLU_CLOCK,
    output tlu_trig_pkg::timestamp_t  TIMESTAMP
);
    import tlu_trig_pkg::*;

    localparam int div_w = $clog2(tlu_clock_half_period);

    typedef enum logic [1:0] {
        s_idle,
        s_wait_low,
        s_clock,
        s_write
    } state_t;

    state_t           state;
    logic [1:0]       veto_sync;
    logic             clr;
    logic             accept;
    logic             half_done;
    logic [5:0]       num_cycles;
    logic [5:0]       bit_cnt;
    logic [div_w-1:0] div_cnt;
    logic [7:0]       timeout_cnt;
    trig_num_t        rx_number;
    trig_num_t        trig_count;
    trig_num_t        number;

    assign clr = RST || soft_rst;
    // zero in the register field stands for 32
    assign num_cycles = {cfg.trigger_clock_cycles == 5'd0, cfg.trigger_clock_cycles};
    assign accept = inputs.trigger_flag && (cfg.mode != mode_disabled)
                    && (!veto_sync[1] || cfg.disable_veto);
    assign half_done = div_cnt == div_w'(tlu_clock_half_period - 1);
    assign number = (cfg.mode == mode_data_handshake) ? rx_number : trig_count;

    always_ff @(posedge BUS_CLK)
    begin
        veto_sync <= {veto_sync[0], EXT_VETO};
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (clr || inputs.reset_flag)
            TIMESTAMP <= '0;
        else
            TIMESTAMP <= TIMESTAMP + 32'd1;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (clr)
        begin
            state <= s_idle;
            fifo_write <= 1'b0;
            TLU_BUSY <= 1'b0;
            TLU_CLOCK <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            timeout_cnt <= '0;
            trig_count <= '0;
            last_trigger_number <= '0;
        end
        else
        begin
            fifo_write <= 1'b0;
            case (state)
                s_idle:
                begin
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    timeout_cnt <= '0;
                    if (accept)
                    begin
                        case (cfg.mode)
                            mode_simple_handshake:
                            begin
                                state <= s_wait_low;
                                TLU_BUSY <= 1'b1;
                            end
                            mode_data_handshake:
                            begin
                                state <= s_clock;
                                TLU_BUSY <= 1'b1;
                            end
                            default:
                                state <= s_write;
                        endcase
                    end
                end
                s_wait_low:
                begin
                    timeout_cnt <= timeout_cnt + 8'd1;
                    if (!inputs.trigger)
                    begin
                        state <= s_write;
                        TLU_BUSY <= 1'b0;
                    end
                    else if (cfg.low_timeout != 8'd0 && timeout_cnt == cfg.low_timeout - 8'd1)
                    begin
                        // trigger stuck high, drop it without a word
                        state <= s_idle;
                        TLU_BUSY <= 1'b0;
                    end
                end
                s_clock:
                begin
                    div_cnt <= half_done ? '0 : div_cnt + 1'b1;
                    if (half_done)
                    begin
                        TLU_CLOCK <= !TLU_CLOCK;
                        // falling edge closes one bit
                        if (TLU_CLOCK)
                        begin
                            bit_cnt <= bit_cnt + 6'd1;
                            if (bit_cnt == num_cycles - 6'd1)
                            begin
                                state <= s_write;
                                TLU_BUSY <= 1'b0;
                            end
                        end
                    end
                end
                s_write:
                begin
                    fifo_write <= 1'b1;
                    trig_count <= trig_count + 32'd1;
                    last_trigger_number <= number;
                    state <= s_idle;
                end
                default:
                    state <= s_idle;
            endcase
        end
    end

    // bit answering a rising TLU_CLOCK is sampled half a period later
    always_ff @(posedge BUS_CLK)
    begin
        if (state == s_idle)
            rx_number <= '0;
        else if (state == s_clock && half_done && TLU_CLOCK)
        begin
            if (cfg.msb_first)
                rx_number <= {rx_number[30:0], inputs.trigger};
            else
                rx_number[bit_cnt[4:0]] <= inputs.trigger;
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (state == s_write)
        begin
            fifo_word.marker <= 1'b1;
            fifo_word.payload <= cfg.write_timestamp ? TIMESTAMP[30:0] : number[30:0];
        end
    end

endmodule

/* hdl/tlu_trigger_fifo.sv */
`timescale 1ns/100ps

module tlu_trigger_fifo #(
    parameter int depth = 8
) (
    input  logic                    BUS_CLK,
    input  logic                    RST,
    input  logic                    soft_rst,
    input  logic                    fifo_write,
    input  tlu_trig_pkg::tlu_word_t fifo_word,
    input  logic                    FIFO_READ,
    output logic                    FIFO_EMPTY,
    output tlu_trig_pkg::tlu_word_t FIFO_DATA,
    output tlu_bus_pkg::bus_data_t  lost_count
);
    import tlu_trig_pkg::*;

    localparam int ptr_w = $clog2(depth);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);
    localparam logic [ptr_w:0] full_count = (ptr_w + 1)'(depth);

    tlu_word_t        mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             full;
    logic             push;
    logic             pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == last_ptr) ? '0 : ptr + 1'b1;
    endfunction

    assign full = count == full_count;
    assign FIFO_EMPTY = count == '0;
    assign push = fifo_write && !full;
    assign pop = FIFO_READ && !FIFO_EMPTY;
    // first word fall through
    assign FIFO_DATA = mem[rd_ptr];

    always_ff @(posedge BUS_CLK)
    begin
        if (push)
            mem[wr_ptr] <= fifo_word;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST || soft_rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            lost_count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            // saturates at 255
            if (fifo_write && full && lost_count != 8'hff)
                lost_count <= lost_count + 8'd1;
        end
    end

endmodule

/* hdl/tlu_controller.sv */
`timescale 1ns/100ps

module tlu_controller (
    input  logic                      BUS_CLK,
    input  logic                      RST,
    input  tlu_bus_pkg::bus_addr_t    BUS_ADD,
    input  tlu_bus_pkg::bus_data_t    BUS_DATA_IN,
    input  logic                      BUS_RD,
    input  logic                      BUS_WR,
    output tlu_bus_pkg::bus_data_t    BUS_DATA_OUT,
    input  logic                      RJ45_TRIGGER,
    input  logic                      LEMO_TRIGGER,
    input  logic                      RJ45_RESET,
    input  logic                      LEMO_RESET,
    input  logic                      EXT_VETO,
    output logic                      RJ45_ENABLED,
    output logic                      TLU_BUSY,
    output logic                      TLU_CLOCK,
    input  logic                      FIFO_READ,
    output logic                      FIFO_EMPTY,
    output tlu_trig_pkg::tlu_word_t   FIFO_DATA,
    output tlu_trig_pkg::timestamp_t  TIMESTAMP
);
    import tlu_bus_pkg::*;
    import tlu_trig_pkg::*;

    tlu_cfg_t    cfg;
    logic        soft_rst;
    tlu_inputs_t inputs;
    logic        fifo_write;
    tlu_word_t   fifo_word;
    trig_num_t   last_trigger_number;
    bus_data_t   lost_count;

    tlu_regs i_tlu_regs (
        .BUS_CLK             (BUS_CLK),
        .RST                 (RST),
        .BUS_ADD             (BUS_ADD),
        .BUS_DATA_IN         (BUS_DATA_IN),
        .BUS_WR              (BUS_WR),
        .BUS_DATA_OUT        (BUS_DATA_OUT),
        .lost_count          (lost_count),
        .last_trigger_number (last_trigger_number),
        .cfg                 (cfg),
        .soft_rst            (soft_rst)
    );

    tlu_input_select i_tlu_input_select (
        .BUS_CLK      (BUS_CLK),
        .RST          (RST),
        .soft_rst     (soft_rst),
        .cfg          (cfg),
        .RJ45_TRIGGER (RJ45_TRIGGER),
        .LEMO_TRIGGER (LEMO_TRIGGER),
        .RJ45_RESET   (RJ45_RESET),
        .LEMO_RESET   (LEMO_RESET),
        .inputs       (inputs),
        .RJ45_ENABLED (RJ45_ENABLED)
    );

    tlu_handshake_fsm i_tlu_handshake_fsm (
        .BUS_CLK             (BUS_CLK),
        .RST                 (RST),
        .soft_rst            (soft_rst),
        .cfg                 (cfg),
        .inputs              (inputs),
        .EXT_VETO            (EXT_VETO),
        .fifo_write          (fifo_write),
        .fifo_word           (fifo_word),
        .last_trigger_number (last_trigger_number),
        .TLU_BUSY            (TLU_BUSY),
        .TLU_CLOCK           (TLU_CLOCK),
        .TIMESTAMP           (TIMESTAMP)
    );

    tlu_trigger_fifo #(
        .depth (fifo_depth)
    ) i_tlu_trigger_fifo (
        .BUS_CLK    (BUS_CLK),
        .RST        (RST),
        .soft_rst   (soft_rst),
        .fifo_write (fifo_write),
        .fifo_word  (fifo_word),
        .FIFO_READ  (FIFO_READ),
        .FIFO_EMPTY (FIFO_EMPTY),
        .FIFO_DATA  (FIFO_DATA),
        .lost_count (lost_count)
    );

endmodule

/* test/tb_tlu_controller.sv */
`timescale 1ns/100ps

module tb_tlu_controller;
    import tlu_bus_pkg::*;
    import tlu_trig_pkg::*;

    localparam int wait_limit = 400;
    localparam int line_lemo_trig = 0;
    localparam int line_rj45_trig = 1;
    localparam int line_lemo_reset = 2;

    logic       BUS_CLK = 1'b0;
    logic       RST;
    bus_addr_t  BUS_ADD;
    bus_data_t  BUS_DATA_IN;
    logic       BUS_RD;
    logic       BUS_WR;
    bus_data_t  BUS_DATA_OUT;
    logic       RJ45_TRIGGER;
    logic       LEMO_TRIGGER;
    logic       RJ45_RESET;
    logic       LEMO_RESET;
    logic       EXT_VETO;
    logic       RJ45_ENABLED;
    logic       TLU_BUSY;
    logic       TLU_CLOCK;
    logic       FIFO_READ;
    logic       FIFO_EMPTY;
    tlu_word_t  FIFO_DATA;
    timestamp_t TIMESTAMP;

    logic [31:0] lfsr_state = 32'hd2c4_9ac6;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic        tlu_clock_q = 1'b0;
    int          clock_rises = 0;
    int          busy_cycles = 0;

    always #10 BUS_CLK = !BUS_CLK;

    tlu_controller i_tlu_controller (
        .BUS_CLK      (BUS_CLK),
        .RST          (RST),
        .BUS_ADD      (BUS_ADD),
        .BUS_DATA_IN  (BUS_DATA_IN),
        .BUS_RD       (BUS_RD),
        .BUS_WR       (BUS_WR),
        .BUS_DATA_OUT (BUS_DATA_OUT),
        .RJ45_TRIGGER (RJ45_TRIGGER),
        .LEMO_TRIGGER (LEMO_TRIGGER),
        .RJ45_RESET   (RJ45_RESET),
        .LEMO_RESET   (LEMO_RESET),
        .EXT_VETO     (EXT_VETO),
        .RJ45_ENABLED (RJ45_ENABLED),
        .TLU_BUSY     (TLU_BUSY),
        .TLU_CLOCK    (TLU_CLOCK),
        .FIFO_READ    (FIFO_READ),
        .FIFO_EMPTY   (FIFO_EMPTY),
        .FIFO_DATA    (FIFO_DATA),
        .TIMESTAMP    (TIMESTAMP)
    );

    // running totals of TLU_CLOCK rises and busy cycles
    always @(negedge BUS_CLK)
    begin
        tlu_clock_q <= TLU_CLOCK;
        if (TLU_CLOCK && !tlu_clock_q)
            clock_rises <= clock_rises + 1;
        if (TLU_BUSY)
            busy_cycles <= busy_cycles + 1;
    end

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = next_lfsr(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got == expected)
        else
        begin
            $display("Error: %s is %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic start_test();
        test_errors = errors;
    endtask

    task automatic finish_test(input string name);
        if (errors == test_errors)
        begin
            tests_passed++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - test_errors);
        end
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        @(negedge BUS_CLK);
        BUS_ADD = addr;
        BUS_DATA_IN = data;
        BUS_WR = 1'b1;
        @(negedge BUS_CLK);
        BUS_WR = 1'b0;
    endtask

    // data shows up one cycle after the address
    task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
        @(negedge BUS_CLK);
        BUS_ADD = addr;
        BUS_RD = 1'b1;
        @(negedge BUS_CLK);
        data = BUS_DATA_OUT;
        BUS_RD = 1'b0;
    endtask

    task automatic soft_reset();
        bus_write(addr_ctrl, 8'h01);
        repeat (2) @(negedge BUS_CLK);
    endtask

    // address 4 first so the upper bytes come from the same snapshot
    task automatic read_trigger_number(output logic [31:0] number);
        bus_data_t data;
        number = '0;
        for (int a = 0; a < 4; a++)
        begin
            bus_read(addr_tlu_num0 + 16'(a), data);
            number = {data, number[31:8]};
        end
    endtask

    task automatic drive_line(input int line, input logic level);
        case (line)
            line_lemo_trig:
                LEMO_TRIGGER = level;
            line_rj45_trig:
                RJ45_TRIGGER = level;
            default:
                LEMO_RESET = level;
        endcase
    endtask

    task automatic send_pulse(input int line);
        @(negedge BUS_CLK);
        drive_line(line, 1'b1);
        repeat (3) @(negedge BUS_CLK);
        drive_line(line, 1'b0);
        repeat (3) @(negedge BUS_CLK);
    endtask

    task automatic get_word(output tlu_word_t word, output bit ok);
        ok = 1'b0;
        word = '0;
        for (int t = 0; t < wait_limit && !ok; t++)
        begin
            @(negedge BUS_CLK);
            ok = !FIFO_EMPTY;
        end
        if (!ok)
        begin
            $display("timeout while waiting for a word in the FIFO");
            errors++;
        end
        else
        begin
            word = FIFO_DATA;
            FIFO_READ = 1'b1;
            @(negedge BUS_CLK);
            FIFO_READ = 0;
        end
    endtask

    // TLU side of the data handshake with one bit per rising TLU_CLOCK
    task automatic send_tlu_number(input logic [31:0] value, input int n,
                                   input bit msb_first, output bit ok);
        bit          seen;
        logic        last;
        int          bit_pos;
        logic [31:0] shifted;
        ok = 1'b1;
        @(negedge BUS_CLK);
        LEMO_TRIGGER = 1'b1;
        last = TLU_CLOCK;
        for (int k = 0; k < n && ok; k++)
        begin
            seen = 1'b0;
            for (int t = 0; t < wait_limit && !seen; t++)
            begin
                @(negedge BUS_CLK);
                seen = TLU_CLOCK && !last;
                last = TLU_CLOCK;
            end
            if (!seen)
            begin
                $display("timeout while waiting for TLU_CLOCK edge %0d of %0d", k + 1, n);
                errors++;
                ok = 1'b0;
            end
            else
            begin
                assert (TLU_BUSY)
                else
                begin
                    $display("TLU_BUSY dropped before the last TLU_CLOCK edge");
                    errors++;
                end
                bit_pos = msb_first ? n - 1 - k : k;
                shifted = value >> bit_pos;
                LEMO_TRIGGER = shifted[0];
            end
        end
        seen = 1'b0;
        for (int t = 0; t < wait_limit && !seen; t++)
        begin
            @(negedge BUS_CLK);
            seen = !TLU_BUSY;
        end
        if (!seen)
        begin
            $display("timeout while waiting for TLU_BUSY to fall");
            errors++;
            ok = 1'b0;
        end
        assert (!TLU_CLOCK)
        else
        begin
            $display("TLU_CLOCK left high after the handshake");
            errors++;
        end
        LEMO_TRIGGER = 1'b0;
    endtask

    initial
    begin
        tlu_word_t   w;
        bit          ok;
        bit          msb;
        bus_data_t   rd;
        logic [31:0] rnd;
        logic [31:0] value;
        logic [31:0] mask;
        logic [31:0] number;
        logic [4:0]  field;
        logic [30:0] prev;
        timestamp_t  ts_before;
        int          n;
        int          count;
        int          mark;
        RST = 1'b1;
        BUS_ADD = '0;
        BUS_DATA_IN = '0;
        BUS_RD = 1'b0;
        BUS_WR = 1'b0;
        RJ45_TRIGGER = 1'b1;
        RJ45_RESET = 1'b1;
        LEMO_TRIGGER = 1'b0;
        LEMO_RESET = 1'b0;
        EXT_VETO = 1'b0;
        FIFO_READ = 1'b0;
        repeat (10) @(negedge BUS_CLK);
        RST = 1'b0;

        start_test();
        for (int a = 1; a <= 3; a++)
        begin
            bus_read(16'(a), rd);
            check_value("BUS_DATA_OUT", {24'd0, rd}, 32'd0);
        end
        rnd = random_bits(24);
        bus_write(addr_cfg1, rnd[7:0]);
        bus_write(addr_cfg2, rnd[15:8]);
        bus_write(addr_timeout, rnd[23:16]);
        for (int a = 1; a <= 3; a++)
        begin
            bus_read(16'(a), rd);
            check_value("BUS_DATA_OUT", {24'd0, rd}, (rnd >> (8 * (a - 1))) & 32'hff);
        end
        soft_reset();
        for (int a = 1; a <= 3; a++)
        begin
            bus_read(16'(a), rd);
            check_value("BUS_DATA_OUT", {24'd0, rd}, 32'd0);
        end
        assert (FIFO_EMPTY && !TLU_BUSY && !TLU_CLOCK && !RJ45_ENABLED)
        else
        begin
            $display("controller not idle after the soft reset");
            errors++;
        end
        finish_test("register access");

        start_test();
        mark = busy_cycles;
        for (int i = 0; i < 3; i++)
            send_pulse(line_lemo_trig);
        repeat (12) @(negedge BUS_CLK);
        assert (FIFO_EMPTY)
        else
        begin
            $display("trigger accepted while the mode is disabled");
            errors++;
        end
        bus_write(addr_cfg1, 8'h01);
        for (int i = 0; i < 5; i++)
        begin
            send_pulse(line_lemo_trig);
            get_word(w, ok);
            check_value("FIFO_DATA.marker", 32'(w.marker), 32'd1);
            check_value("FIFO_DATA.payload", {1'b0, w.payload}, 32'(i));
        end
        check_value("TLU_BUSY cycles", busy_cycles - mark, 32'd0);
        finish_test("mode gating");

        start_test();
        for (int k = 0; k < 6; k++)
        begin
            msb = k[0];
            rnd = random_bits(5);
            field = rnd[4:0];
            n = (field == 5'd0) ? 32 : int'(field);
            value = random_bits(32);
            mask = (n == 32) ? 32'hffff_ffff : (32'd1 << n) - 32'd1;
            bus_write(addr_cfg2, {3'b000, field});
            bus_write(addr_cfg1, msb ? 8'h07 : 8'h03);
            mark = clock_rises;
            send_tlu_number(value, n, msb, ok);
            if (ok)
            begin
                get_word(w, ok);
                check_value("FIFO_DATA.marker", 32'(w.marker), 32'd1);
                check_value("FIFO_DATA.payload", {1'b0, w.payload}, value & mask & 32'h7fff_ffff);
                check_value("TLU_CLOCK rising edges", clock_rises - mark, n);
                read_trigger_number(number);
                check_value("trigger number", number, value & mask);
            end
        end
        finish_test("data handshake");

        start_test();
        soft_reset();
        bus_write(addr_cfg1, 8'h01);
        for (int i = 0; i < 11; i++)
            send_pulse(line_lemo_trig);
        rd = '0;
        for (int t = 0; t < 50 && rd != 8'd3; t++)
            bus_read(addr_ctrl, rd);
        check_value("lost_count", {24'd0, rd}, 32'd3);
        count = 0;
        ok = 1'b0;
        for (int t = 0; t < 12 && !ok; t++)
        begin
            if (FIFO_EMPTY)
                ok = 1'b1;
            else
            begin
                check_value("FIFO_DATA.payload", {1'b0, FIFO_DATA.payload}, 32'(count));
                FIFO_READ = 1'b1;
                @(negedge BUS_CLK);
                FIFO_READ = 1'b0;
                count++;
            end
        end
        check_value("stored words", count, 32'd8);
        finish_test("overflow");

        start_test();
        // write_timestamp and enable_reset
        bus_write(addr_cfg2, 8'ha0);
        prev = '0;
        for (int i = 0; i < 4; i++)
        begin
            send_pulse(line_lemo_trig);
            get_word(w, ok);
            assert (i == 0 || w.payload > prev)
            else
            begin
                $display("Error: FIFO_DATA.payload is %h, not above %h", w.payload, prev);
                errors++;
            end
            prev = w.payload;
        end
        ts_before = TIMESTAMP;
        send_pulse(line_lemo_reset);
        ok = 1'b0;
        for (int t = 0; t < wait_limit && !ok; t++)
        begin
            @(negedge BUS_CLK);
            ok = TIMESTAMP < ts_before;
        end
        assert (ok)
        else
        begin
            $display("TLU reset pulse did not clear the timestamp");
            errors++;
        end
        // two synchronizer stages on the veto
        EXT_VETO = 1'b1;
        repeat (3) @(negedge BUS_CLK);
        send_pulse(line_lemo_trig);
        repeat (12) @(negedge BUS_CLK);
        assert (FIFO_EMPTY)
        else
        begin
            $display("trigger accepted while EXT_VETO was high");
            errors++;
        end
        EXT_VETO = 1'b0;
        repeat (3) @(negedge BUS_CLK);
        send_pulse(line_lemo_trig);
        get_word(w, ok);
        finish_test("timestamp reset veto");

        start_test();
        soft_reset();
        bus_write(addr_cfg1, 8'h01);
        check_value("RJ45_ENABLED", 32'(RJ45_ENABLED), 32'd0);
        RJ45_TRIGGER = 1'b0;
        ok = 1'b0;
        for (int t = 0; t < wait_limit && !ok; t++)
        begin
            @(negedge BUS_CLK);
            ok = RJ45_ENABLED;
        end
        assert (ok)
        else
        begin
            $display("RJ45_ENABLED did not rise with a low RJ45 trigger line");
            errors++;
        end
        send_pulse(line_lemo_trig);
        repeat (12) @(negedge BUS_CLK);
        assert (FIFO_EMPTY)
        else
        begin
            $display("LEMO trigger accepted while the RJ45 port is selected");
            errors++;
        end
        send_pulse(line_rj45_trig);
        get_word(w, ok);
        check_value("FIFO_DATA.payload", {1'b0, w.payload}, 32'd0);
        RJ45_TRIGGER = 1'b1;
        finish_test("port selection");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* tlu_ctrl.f */
hdl/tlu_bus_pkg.sv
hdl/tlu_trig_pkg.sv
hdl/tlu_regs.sv
hdl/tlu_input_select.sv
hdl/tlu_handshake_fsm.sv
hdl/tlu_trigger_fifo.sv
hdl/tlu_controller.sv
test/tb_tlu_controller.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the TLU controller testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_tlu_controller

verilator --binary --assert --top-module "$TOP" -Mdir obj_dir -f tlu_ctrl.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
